/* filelist.f */
+incdir+logic
logic/rom_guard_pkg.sv
logic/rom_array.sv
logic/rom_checker.sv
logic/rom_sel_mux.sv
logic/rom_guard_top.sv
bench/rom_guard_monitor.sv
bench/rom_guard_tb.sv

/* Bender.yml */
package:
  name: rom_guard

sources:
  - include_dirs:
      - logic
    files:
      - logic/rom_guard_pkg.sv
      - logic/rom_array.sv
      - logic/rom_checker.sv
      - logic/rom_sel_mux.sv
      - logic/rom_guard_top.sv

  - target: test
    include_dirs:
      - logic
    files:
      - bench/rom_guard_monitor.sv
      - bench/rom_guard_tb.sv

/* bench/rom_guard_tb.sv */
// Needs the RTL package and settings header; runs a good image and a tampered image side by side
`include "rom_guard_settings.svh"

module rom_guard_tb
  import rom_guard_pkg::*;
();

  // Phase lengths in clock cycles
  localparam int RESET_CYCLES  = 4;
  localparam int CHECK_CYCLES  = 66;
  localparam int NUM_REQS      = 200;
  localparam int MAX_GAP       = 3;
  localparam int GLITCH_CYCLES = 5;
  localparam int TAIL_CYCLES   = 8;

  // Twice the longest expected run
  localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + CHECK_CYCLES + NUM_REQS * (MAX_GAP + 1)
                                       + GLITCH_CYCLES + TAIL_CYCLES);

  // Good image with one data bit of word 5 flipped
  localparam rom_image_t BAD_IMAGE = rom_plain_image() ^ (rom_image_t'(1) << (5 * `ROM_DW + 3));

  logic        clk;
  logic        rst_n;
  sel_mubi_t   sel_glitch;
  logic        bus_req_valid;
  bus_req_t    bus_req;
  logic        end_of_test;
  logic [31:0] lcg_state;

  // Main DUT outputs
  logic        bus_req_ready;
  logic        bus_rsp_valid;
  bus_rsp_t    bus_rsp;
  logic        check_done;
  logic        check_fail;
  logic        alert;

  // Tampered DUT outputs
  logic        bad_ready;
  logic        bad_rsp_valid;
  logic        bad_done;
  logic        bad_fail;
  logic        bad_alert;

  int          error_count;
  int          check_count;

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  rom_guard_top dut_i (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .sel_glitch_i    (sel_glitch),
    .bus_req_valid_i (bus_req_valid),
    .bus_req_i       (bus_req),
    .bus_req_ready_o (bus_req_ready),
    .bus_rsp_valid_o (bus_rsp_valid),
    .bus_rsp_o       (bus_rsp),
    .check_done_o    (check_done),
    .check_fail_o    (check_fail),
    .alert_o         (alert)
  );

  // Same bus traffic but the select is never glitched here
  // No response ever comes back, so the response word stays open
  rom_guard_top #(
    .PLAIN_IMAGE (BAD_IMAGE)
  ) dut_bad_i (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .sel_glitch_i    (4'b0000),
    .bus_req_valid_i (bus_req_valid),
    .bus_req_i       (bus_req),
    .bus_req_ready_o (bad_ready),
    .bus_rsp_valid_o (bad_rsp_valid),
    .bus_rsp_o       (),
    .check_done_o    (bad_done),
    .check_fail_o    (bad_fail),
    .alert_o         (bad_alert)
  );

  rom_guard_monitor #(
    .NUM_REQS      (NUM_REQS),
    .CHECK_LATENCY (CHECK_CYCLES)
  ) monitor_i (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .sel_glitch_i    (sel_glitch),
    .bus_req_valid_i (bus_req_valid),
    .bus_req_i       (bus_req),
    .bus_req_ready_i (bus_req_ready),
    .bus_rsp_valid_i (bus_rsp_valid),
    .bus_rsp_i       (bus_rsp),
    .check_done_i    (check_done),
    .check_fail_i    (check_fail),
    .alert_i         (alert),
    .bad_ready_i     (bad_ready),
    .bad_rsp_valid_i (bad_rsp_valid),
    .bad_done_i      (bad_done),
    .bad_fail_i      (bad_fail),
    .bad_alert_i     (bad_alert),
    .end_of_test_i   (end_of_test),
    .error_count_o   (error_count),
    .check_count_o   (check_count)
  );

  // 32-bit LCG whose upper bits are used since the low ones repeat quickly
  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Holds valid until the DUT takes the request and returns on a falling edge
  task automatic bus_read(input logic [`ROM_AW-1:0] addr);
    logic taken;
    bus_req_valid = 1'b1;
    bus_req.addr  = addr;
    taken         = 1'b0;
    while (!taken) begin
      @(posedge clk);
      taken = bus_req_ready;
    end
    @(negedge clk);
    bus_req_valid = 1'b0;
  endtask

  task automatic random_reads(input int count);
    logic [31:0] r;
    int          gap;
    for (int i = 0; i < count; i++) begin
      lcg_state = lcg_next(lcg_state);
      r         = lcg_state;
      gap       = int'(r[17:16]);
      repeat (gap) @(negedge clk);
      bus_read(r[29:24]);
    end
  endtask

  task automatic inject_glitch(input sel_mubi_t value, input int cycles);
    sel_glitch = value;
    repeat (cycles) @(negedge clk);
    sel_glitch = '0;
  endtask

  initial begin
    rst_n         = 1'b1;
    sel_glitch    = '0;
    bus_req_valid = 1'b0;
    bus_req       = '0;
    end_of_test   = 1'b0;
    lcg_state     = 32'd16071;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b0;
    // First request stays pending through the whole check
    random_reads(NUM_REQS / 2);
    // Invalid code first and then a True to False flip
    inject_glitch(4'b0001, 3);
    inject_glitch(4'b1111, GLITCH_CYCLES - 3);
    random_reads(NUM_REQS - NUM_REQS / 2);
    repeat (TAIL_CYCLES) @(negedge clk);
    end_of_test = 1'b1;
    @(negedge clk);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin : watchdog
    int cycle_count;
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the bus traffic never completed", cycle_count);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* bench/rom_guard_monitor.sv */
// Samples both DUTs on the rising edge; expects a 66-cycle check and one-cycle bus read latency
`include "rom_guard_settings.svh"

module rom_guard_monitor
  import rom_guard_pkg::*;
#(
  parameter int NUM_REQS      = 200,
  parameter int CHECK_LATENCY = 66
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  sel_mubi_t sel_glitch_i,
  // Main DUT bus and status
  input  logic      bus_req_valid_i,
  input  bus_req_t  bus_req_i,
  input  logic      bus_req_ready_i,
  input  logic      bus_rsp_valid_i,
  input  bus_rsp_t  bus_rsp_i,
  input  logic      check_done_i,
  input  logic      check_fail_i,
  input  logic      alert_i,
  // Tampered DUT status
  input  logic      bad_ready_i,
  input  logic      bad_rsp_valid_i,
  input  logic      bad_done_i,
  input  logic      bad_fail_i,
  input  logic      bad_alert_i,
  input  logic      end_of_test_i,
  output int        error_count_o,
  output int        check_count_o
);

  int                 errors = 0;
  int                 checks = 0;
  int                 rsp_count = 0;
  // Rising edges since reset release
  int                 cyc;
  // High once the check is due to have finished
  logic               done_exp;
  logic               alert_exp;
  // Request taken at the last edge with its answer due at this one
  logic               pend;
  logic [`ROM_AW-1:0] pend_addr;
  logic [`ROM_DW-1:0] exp_word;
  logic [`ROM_DW-1:0] scr_word;

  // Plain content with parity on top
  function automatic logic [`ROM_DW-1:0] plain_word(logic [`ROM_AW-1:0] a);
    logic [15:0] d;
    d = (16'(a) * 16'h9E37) ^ 16'h5A5A;
    return {^d, d};
  endfunction

  function automatic logic [`ROM_DW-1:0] scramble_mask(logic [`ROM_AW-1:0] a);
    return {a, ~a, a[4:0]};
  endfunction

  function automatic logic [`ROM_DW-1:0] digest_step(logic [`ROM_DW-1:0] dig,
                                                     logic [`ROM_DW-1:0] w);
    return {dig[`ROM_DW-2:0], dig[`ROM_DW-1]} ^ w;
  endfunction

  // Clear word of an address
  // Last one is rebuilt from the digest of the rest
  function automatic logic [`ROM_DW-1:0] expected_word(logic [`ROM_AW-1:0] a);
    logic [`ROM_DW-1:0] dig;
    logic [`ROM_AW-1:0] ia;
    if (a != `ROM_DEPTH - 1) begin
      return plain_word(a);
    end
    dig = '0;
    for (int i = 0; i < `ROM_DEPTH - 1; i++) begin
      ia  = i[`ROM_AW-1:0];
      dig = digest_step(dig, plain_word(ia) ^ scramble_mask(ia));
    end
    return dig ^ scramble_mask(a);
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error at %0t: %s expected %0h got %0h", $time, name, exp, act);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%s", what);
  endtask

  always @(posedge clk_i) begin
    if (rst_ni) begin
      cyc       = 0;
      alert_exp = 1'b0;
      pend      = 1'b0;
    end else begin
      // Main DUT finishes a fixed number of edges after reset release and never fails
      done_exp = (cyc >= CHECK_LATENCY);
      check_value("check_done_o", done_exp, check_done_i);
      check_value("check_fail_o", 1'b0, check_fail_i);
      // Bus opens with done and closes while the select is glitched
      check_value("bus_req_ready_o", done_exp && (sel_glitch_i == '0), bus_req_ready_i);
      check_value("bus_rsp_valid_o", pend, bus_rsp_valid_i);
      if (pend && bus_rsp_valid_i) begin
        exp_word = expected_word(pend_addr);
        scr_word = exp_word ^ scramble_mask(pend_addr);
        check_value("bus_rsp_o.data", exp_word[`ROM_DW-2:0], bus_rsp_i.data);
        check_value("bus_rsp_o.parity", exp_word[`ROM_DW-1], bus_rsp_i.parity);
        // Stored bits must not leak out on the bus
        if (scr_word[`ROM_DW-2:0] != exp_word[`ROM_DW-2:0] &&
            bus_rsp_i.data == scr_word[`ROM_DW-2:0]) begin
          report_failure($sformatf("Bus returned scrambled data for address %0d", pend_addr));
        end
        rsp_count++;
      end
      // Sticky alert rises one edge after the first glitch
      check_value("alert_o", alert_exp, alert_i);
      if (done_exp && sel_glitch_i != '0) begin
        alert_exp = 1'b1;
      end
      pend      = bus_req_valid_i && bus_req_ready_i;
      pend_addr = bus_req_i.addr;
      // Tampered DUT fails on time with the bus shut and no alert
      check_value("tampered check_done_o", done_exp, bad_done_i);
      check_value("tampered check_fail_o", done_exp, bad_fail_i);
      check_value("tampered bus_req_ready_o", 1'b0, bad_ready_i);
      check_value("tampered bus_rsp_valid_o", 1'b0, bad_rsp_valid_i);
      check_value("tampered alert_o", 1'b0, bad_alert_i);
      cyc++;
    end
  end

  // Every accepted read must have been answered by the end of the run
  always @(posedge end_of_test_i) begin
    if (rsp_count != NUM_REQS) begin
      report_failure($sformatf("Saw %0d bus responses instead of %0d", rsp_count, NUM_REQS));
    end
  end

  assign error_count_o = errors;
  assign check_count_o = checks;

endmodule

/* logic/rom_guard_top.sv */
// Bus opens only after a clean digest check; sel_glitch_i is a fault-injection port, tie to zero in use
module rom_guard_top
  import rom_guard_pkg::*;
#(
  // Plain ROM content, handed down to the array
  parameter rom_image_t PLAIN_IMAGE = rom_plain_image()
) (
  input  logic      clk_i,
  input  logic      rst_ni,

  // XORed into the select between checker and mux
  input  sel_mubi_t sel_glitch_i,

  // Bus port
  input  logic      bus_req_valid_i,
  input  bus_req_t  bus_req_i,
  output logic      bus_req_ready_o,
  output logic      bus_rsp_valid_o,
  output bus_rsp_t  bus_rsp_o,

  // Status
  output logic      check_done_o,
  output logic      check_fail_o,
  output logic      alert_o
);

  rom_req_t  chk_req;
  rom_req_t  rom_req;
  sel_mubi_t chk_sel;
  sel_mubi_t mux_sel;
  logic      rom_rvalid;
  rom_word_u rom_scr_rdata;
  rom_word_u rom_clr_rdata;
  rom_word_u chk_rdata;

  // Glitch model on the select wire
  assign mux_sel = chk_sel ^ sel_glitch_i;

  rom_array #(
    .PLAIN_IMAGE (PLAIN_IMAGE)
  ) u_rom_array (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (rom_req),
    .rvalid_o    (rom_rvalid),
    .scr_rdata_o (rom_scr_rdata),
    .clr_rdata_o (rom_clr_rdata)
  );

  rom_checker u_rom_checker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rom_req_o    (chk_req),
    .rom_rvalid_i (rom_rvalid),
    .rom_rdata_i  (chk_rdata),
    .sel_bus_o    (chk_sel),
    .done_o       (check_done_o),
    .fail_o       (check_fail_o)
  );

  rom_sel_mux u_rom_sel_mux (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .sel_bus_i       (mux_sel),
    .bus_req_valid_i (bus_req_valid_i),
    .bus_req_i       (bus_req_i),
    .bus_req_ready_o (bus_req_ready_o),
    .bus_rsp_valid_o (bus_rsp_valid_o),
    .bus_rsp_o       (bus_rsp_o),
    .chk_req_i       (chk_req),
    .chk_rdata_o     (chk_rdata),
    .rom_req_o       (rom_req),
    .rom_rvalid_i    (rom_rvalid),
    .rom_scr_rdata_i (rom_scr_rdata),
    .rom_clr_rdata_i (rom_clr_rdata),
    .alert_o         (alert_o)
  );

endmodule

/* logic/rom_sel_mux.sv */
// One-way switch from checker to bus; alert is sticky until reset and the bus has no back-pressure
module rom_sel_mux
  import rom_guard_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  // Select from the checker, True hands the ROM to the bus
  input  sel_mubi_t sel_bus_i,

  // Bus request, valid/ready
  input  logic      bus_req_valid_i,
  input  bus_req_t  bus_req_i,
  output logic      bus_req_ready_o,

  // Bus response, single-cycle pulse
  output logic      bus_rsp_valid_o,
  output bus_rsp_t  bus_rsp_o,

  // Checker side
  input  rom_req_t  chk_req_i,
  output rom_word_u chk_rdata_o,

  // ROM side
  output rom_req_t  rom_req_o,
  input  logic      rom_rvalid_i,
  input  rom_word_u rom_scr_rdata_i,
  input  rom_word_u rom_clr_rdata_i,

  output logic      alert_o
);

  // Select history
  // sel_q can only move towards True, sel_qq is one cycle behind it
  sel_mubi_t sel_q;
  sel_mubi_t sel_qq;
  logic      sel_invalid;
  logic      sel_reverted;
  logic      sel_q_reverted;
  logic      alert_q;
  logic      bus_sel;

  always_ff @(posedge clk_i or posedge rst_ni) begin
    if (rst_ni) begin
      sel_q   <= SEL_FALSE;
      sel_qq  <= SEL_FALSE;
      alert_q <= 1'b0;
    end else begin
      sel_q   <= sel_or_hi(sel_q, sel_bus_i);
      sel_qq  <= sel_q;
      alert_q <= alert_q | sel_invalid | sel_reverted | sel_q_reverted;
    end
  end

  // Corrupt code on the input or in the register
  assign sel_invalid = sel_test_invalid(sel_bus_i) || sel_test_invalid(sel_q);

  // Input falls back to checker after the bus was granted
  assign sel_reverted = sel_test_true_loose(sel_q) && sel_test_false_loose(sel_bus_i);

  // Register itself lost its True value
  assign sel_q_reverted = sel_test_true_loose(sel_qq) && sel_test_false_loose(sel_q);

  assign alert_o = alert_q;

  // Bus owns the ROM only on a strictly True select
  assign bus_sel         = sel_test_true_strict(sel_bus_i);
  assign bus_req_ready_o = bus_sel;

  always_comb begin
    if (bus_sel) begin
      rom_req_o.req  = bus_req_valid_i;
      rom_req_o.addr = bus_req_i.addr;
    end else begin
      rom_req_o = chk_req_i;
    end
  end

  // Read data belongs to the bus if the select was True last cycle
  assign bus_rsp_valid_o  = sel_test_true_strict(sel_q) && rom_rvalid_i;
  assign bus_rsp_o.data   = rom_clr_rdata_i.fields.data;
  assign bus_rsp_o.parity = rom_clr_rdata_i.fields.parity;

  // Checker digests the raw stored bits
  assign chk_rdata_o = rom_scr_rdata_i;

endmodule

/* logic/rom_checker.sv */
// Runs once after reset, reads every word in order and assumes the ROM answers each read next cycle
`include "rom_guard_settings.svh"

module rom_checker
  import rom_guard_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  // ROM side, through the mux
  output rom_req_t  rom_req_o,
  input  logic      rom_rvalid_i,
  input  rom_word_u rom_rdata_i,

  // Select towards the mux, True only after a matching digest
  output sel_mubi_t sel_bus_o,

  // Status
  output logic      done_o,
  output logic      fail_o
);

  typedef enum logic [1:0] {
    ST_READ,
    ST_CMP,
    ST_DONE
  } state_e;

  localparam int unsigned LAST = `ROM_DEPTH - 1;
  localparam logic [`ROM_AW-1:0] LAST_ADDR = LAST[`ROM_AW-1:0];

  state_e             state_q;
  // Issue counter, top bit set once every address has gone out
  logic [`ROM_AW:0]   addr_q;
  // Count of returned words
  logic [`ROM_AW-1:0] rcnt_q;
  logic [`ROM_DW-1:0] dig_q;
  logic               match_q;
  logic               done_q;
  logic               fail_q;
  sel_mubi_t          sel_q;
  logic               issue;
  logic               last_rsp;

  // One read per cycle from reset release until all words are out
  assign issue = (state_q == ST_READ) && !addr_q[`ROM_AW];

  // Word holding the stored digest
  assign last_rsp = rom_rvalid_i && (rcnt_q == LAST_ADDR);

  always_ff @(posedge clk_i or posedge rst_ni) begin
    if (rst_ni) begin
      state_q <= ST_READ;
      addr_q  <= '0;
      rcnt_q  <= '0;
      dig_q   <= '0;
      match_q <= 1'b0;
      done_q  <= 1'b0;
      fail_q  <= 1'b0;
      sel_q   <= SEL_FALSE;
    end else begin
      case (state_q)
        ST_READ: begin
          if (issue) begin
            addr_q <= addr_q + 1'b1;
          end
          if (rom_rvalid_i) begin
            rcnt_q <= rcnt_q + 1'b1;
            // Last word is compared, all others are folded
            if (last_rsp) begin
              match_q <= (rom_rdata_i.raw == dig_q);
              state_q <= ST_CMP;
            end else begin
              dig_q <= rom_fold(dig_q, rom_rdata_i.raw);
            end
          end
        end
        ST_CMP: begin
          done_q  <= 1'b1;
          fail_q  <= !match_q;
          // Bus opens in the same cycle that done rises
          sel_q   <= match_q ? SEL_TRUE : SEL_FALSE;
          state_q <= ST_DONE;
        end
        // Finished, everything holds until the next reset
        default: begin
          state_q <= ST_DONE;
        end
      endcase
    end
  end

  assign rom_req_o.req  = issue;
  assign rom_req_o.addr = addr_q[`ROM_AW-1:0];
  assign sel_bus_o      = sel_q;
  assign done_o         = done_q;
  assign fail_o         = fail_q;

endmodule

/* logic/rom_array.sv */
// XOR-mask scrambling only, no cipher and no ECC; one-cycle read latency, no stall
`include "rom_guard_settings.svh"

module rom_array
  import rom_guard_pkg::*;
#(
  // Plain content, override to build a tampered image
  parameter rom_image_t PLAIN_IMAGE = rom_plain_image()
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  rom_req_t  req_i,
  output logic      rvalid_o,
  output rom_word_u scr_rdata_o,
  output rom_word_u clr_rdata_o
);

  // Apply the address mask to every plain word
  function automatic rom_image_t scramble_image(rom_image_t plain);
    rom_image_t         scr;
    logic [`ROM_AW-1:0] a;
    for (int i = 0; i < `ROM_DEPTH; i++) begin
      a      = i[`ROM_AW-1:0];
      scr[i] = plain[i] ^ rom_key_mask(a);
    end
    return scr;
  endfunction

  // Stored image, fixed at elaboration
  localparam rom_image_t SCR_IMAGE = scramble_image(PLAIN_IMAGE);

  logic               rvalid_q;
  logic [`ROM_DW-1:0] rdata_q;
  logic [`ROM_AW-1:0] addr_q;

  // Read strobe
  always_ff @(posedge clk_i or posedge rst_ni) begin
    if (rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  // Word and address are captured together
  // Address is kept so the clear port can undo the mask
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= SCR_IMAGE[req_i.addr];
      addr_q  <= req_i.addr;
    end
  end

  assign rvalid_o = rvalid_q;

  // Raw stored bits for the digest
  assign scr_rdata_o.raw = rdata_q;

  // Descrambled word for the bus
  assign clr_rdata_o.raw = rdata_q ^ rom_key_mask(addr_q);

endmodule

/* logic/rom_guard_pkg.sv */
// Select codes are 4-bit multi-bit values; content and mask rules assume ROM_AW 6 and ROM_DW 17
`include "rom_guard_settings.svh"

package rom_guard_pkg;

  // Multi-bit select
  // Only the two codes below are legal, everything else is a fault
  typedef logic [3:0] sel_mubi_t;

  parameter sel_mubi_t SEL_TRUE  = 4'b1010;
  parameter sel_mubi_t SEL_FALSE = 4'b0101;

  // Parity sits in the top bit of a stored word
  typedef struct packed {
    logic               parity;
    logic [`ROM_DW-2:0] data;
  } rom_fields_t;

  // Checker folds raw bits, bus reads the fields
  typedef union packed {
    logic [`ROM_DW-1:0] raw;
    rom_fields_t        fields;
  } rom_word_u;

  typedef struct packed {
    logic [`ROM_AW-1:0] addr;
  } bus_req_t;

  typedef struct packed {
    logic [`ROM_DW-2:0] data;
    logic               parity;
  } bus_rsp_t;

  typedef struct packed {
    logic               req;
    logic [`ROM_AW-1:0] addr;
  } rom_req_t;

  // Whole image, word i at index i
  typedef logic [`ROM_DEPTH-1:0][`ROM_DW-1:0] rom_image_t;

  function automatic logic sel_test_invalid(sel_mubi_t s);
    return (s != SEL_TRUE) && (s != SEL_FALSE);
  endfunction

  function automatic logic sel_test_true_strict(sel_mubi_t s);
    return s == SEL_TRUE;
  endfunction

  // Loose tests treat invalid codes as the opposite value
  function automatic logic sel_test_true_loose(sel_mubi_t s);
    return s != SEL_FALSE;
  endfunction

  function automatic logic sel_test_false_loose(sel_mubi_t s);
    return s != SEL_TRUE;
  endfunction

  // OR on the bits that are high in True, AND on the others
  // True wins, so the result never drops back to False
  function automatic sel_mubi_t sel_or_hi(sel_mubi_t a, sel_mubi_t b);
    return (SEL_TRUE & (a | b)) | (~SEL_TRUE & (a & b));
  endfunction

  // Plain word of an address, before scrambling
  function automatic rom_word_u rom_plain_word(logic [`ROM_AW-1:0] a);
    logic [15:0] prod;
    rom_word_u   w;
    prod = 16'(a) * 16'h9E37;
    w.fields.data   = prod ^ 16'h5A5A;
    w.fields.parity = ^w.fields.data;
    return w;
  endfunction

  // Address-keyed scramble mask
  function automatic logic [`ROM_DW-1:0] rom_key_mask(logic [`ROM_AW-1:0] a);
    return {a, ~a, a[4:0]};
  endfunction

  // One digest step: rotate left by one, then XOR in the scrambled word
  function automatic logic [`ROM_DW-1:0] rom_fold(logic [`ROM_DW-1:0] dig,
                                                  logic [`ROM_DW-1:0] w);
    return {dig[`ROM_DW-2:0], dig[`ROM_DW-1]} ^ w;
  endfunction

  // Default plain image
  // Last word is picked so that its scrambled value equals the digest of all the others
  function automatic rom_image_t rom_plain_image();
    rom_image_t         img;
    rom_word_u          w;
    logic [`ROM_DW-1:0] dig;
    logic [`ROM_AW-1:0] a;
    dig = '0;
    for (int i = 0; i < `ROM_DEPTH - 1; i++) begin
      a      = i[`ROM_AW-1:0];
      w      = rom_plain_word(a);
      img[i] = w.raw;
      dig    = rom_fold(dig, w.raw ^ rom_key_mask(a));
    end
    a = '1;
    img[`ROM_DEPTH-1] = dig ^ rom_key_mask(a);
    return img;
  endfunction

endpackage

/* logic/rom_guard_settings.svh */
// Sizes are fixed at build time; the mask rule in the package assumes a 6-bit address and 17-bit word
`ifndef ROM_GUARD_SETTINGS_SVH
`define ROM_GUARD_SETTINGS_SVH

// ROM geometry

// Word address width
`define ROM_AW 6

// Stored word width
// 16 data bits plus one parity bit on top
`define ROM_DW 17

// Number of words in the image
// Last word holds the expected digest
`define ROM_DEPTH 64

`endif
